// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // ****************************************
    // major opcodes
    // ****************************************
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub and sra.

    // field positions
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;
    localparam int IMM_I_LSB  = 20;
    localparam int IMM_U_LSB  = 12;

endpackage

`default_nettype wire

// File: source/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  shamt_t;

    // ****************************************
    // execute unit controls
    // ****************************************
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui.
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } shift_op_t;

    typedef enum logic {
        RES_ALU,
        RES_SHIFT
    } res_sel_t;

endpackage

`default_nettype wire

// File: source/rv_instr_queue.sv
`default_nettype none

module rv_instr_queue
    import rv_isa_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  wire         i_clk,
    input  wire         i_arst_n,
    input  wire         i_valid,
    input  wire instr_t i_instr,
    output logic        o_valid,
    output instr_t      o_instr,
    output logic        o_credit
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    instr_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign pop     = (count != '0);     // decode never stalls.
    assign o_valid = pop;
    assign o_instr = mem[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
            mem[wr_ptr] <= i_instr;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (i_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({i_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            o_credit <= pop;            // one credit per freed slot.
        end
    end

    // sender must hold a credit for every write
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> (count != QUEUE_DEPTH))
        else $error("instruction written into a full queue");

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`default_nettype none

module rv_regfile
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_arst_n,
    input  wire reg_idx_t i_rs1,
    input  wire reg_idx_t i_rs2,
    output word_t         o_rs1_data,
    output word_t         o_rs2_data,
    input  wire           i_we,
    input  wire reg_idx_t i_rd,
    input  wire word_t    i_wdata
);

    word_t regs [1:31];     // x0 has no storage.

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we)
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    // decode drops the write enable for rd = x0
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_we |-> (i_rd != '0))
        else $error("write to x0 reached the register file");

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`default_nettype none

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_arst_n,
    input  wire           i_valid,
    input  wire instr_t   i_instr,
    output reg_idx_t      o_rs1,
    output reg_idx_t      o_rs2,
    input  wire word_t    i_rs1_data,
    input  wire word_t    i_rs2_data,
    input  wire           i_ex_valid,
    input  wire reg_idx_t i_ex_rd,
    input  wire word_t    i_ex_data,
    input  wire           i_wb_valid,
    input  wire reg_idx_t i_wb_rd,
    input  wire word_t    i_wb_data,
    output logic          o_valid,
    output logic          o_illegal,
    output word_t         o_op_a,
    output word_t         o_op_b,
    output alu_op_t       o_alu_op,
    output shift_op_t     o_shift_op,
    output res_sel_t      o_res_sel,
    output reg_idx_t      o_rd
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      fwd_a;
    word_t      fwd_b;
    alu_op_t    alu_op;
    shift_op_t  shift_op;
    res_sel_t   res_sel;
    logic       use_imm;
    logic       use_u;
    logic       illegal;
    logic       base;
    logic       alt;

    assign opcode = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[FUNCT3_LSB +: 3];
    assign funct7 = i_instr[FUNCT7_LSB +: 7];
    assign rd     = i_instr[RD_LSB +: 5];
    assign o_rs1  = i_instr[RS1_LSB +: 5];
    assign o_rs2  = i_instr[RS2_LSB +: 5];
    assign imm_i  = {{20{i_instr[31]}}, i_instr[IMM_I_LSB +: 12]};
    assign imm_u  = {i_instr[IMM_U_LSB +: 20], 12'b0};
    assign base   = (funct7 == F7_BASE);
    assign alt    = (funct7 == F7_ALT);

    // ****************************************
    // instruction decode
    // ****************************************
    always_comb
    begin
        alu_op   = ALU_ADD;
        shift_op = SH_SLL;
        res_sel  = RES_ALU;
        use_imm  = (opcode == OPC_OP_IMM);
        use_u    = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM:
            begin
                case (funct3)
                    F3_ADD_SUB:
                    begin
                        alu_op  = (!use_imm && alt) ? ALU_SUB : ALU_ADD;
                        illegal = !use_imm && !base && !alt;
                    end
                    F3_SLL:
                    begin
                        res_sel = RES_SHIFT;
                        illegal = !base;            // also rejects shamt[5].
                    end
                    F3_SRL_SRA:
                    begin
                        res_sel  = RES_SHIFT;
                        shift_op = alt ? SH_SRA : SH_SRL;
                        illegal  = !base && !alt;
                    end
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                endcase
                // register forms need a clean funct7
                if (!use_imm && funct3 != F3_ADD_SUB && funct3 != F3_SRL_SRA && !base)
                    illegal = 1'b1;
            end
            OPC_LUI:
            begin
                alu_op = ALU_PASS_B;
                use_u  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // execute result is newer than write-back
    assign fwd_a = (i_ex_valid && i_ex_rd == o_rs1) ? i_ex_data :
                   (i_wb_valid && i_wb_rd == o_rs1) ? i_wb_data : i_rs1_data;
    assign fwd_b = (i_ex_valid && i_ex_rd == o_rs2) ? i_ex_data :
                   (i_wb_valid && i_wb_rd == o_rs2) ? i_wb_data : i_rs2_data;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
        end
        else
        begin
            o_valid   <= i_valid && !illegal && (rd != '0);
            o_illegal <= i_valid && illegal;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_op_a     <= fwd_a;
            o_op_b     <= use_u ? imm_u : (use_imm ? imm_i : fwd_b);
            o_alu_op   <= alu_op;
            o_shift_op <= shift_op;
            o_res_sel  <= res_sel;
            o_rd       <= rd;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`default_nettype none

module rv_alu
    import rv_pipe_pkg::*;
(
    input  wire word_t   i_op_a,
    input  wire word_t   i_op_b,
    input  wire alu_op_t i_op,
    output word_t        o_result
);

    logic        sub;
    logic [32:0] sum;
    logic        lt_s;
    logic        lt_u;

    // one adder serves add, sub and both compares
    assign sub  = (i_op == ALU_SUB) || (i_op == ALU_SLT) || (i_op == ALU_SLTU);
    assign sum  = {1'b0, i_op_a} + {1'b0, i_op_b ^ {32{sub}}} + {32'b0, sub};
    assign lt_u = !sum[32];                     // borrow out.
    assign lt_s = (i_op_a[31] != i_op_b[31]) ? i_op_a[31] : sum[31];

    always_comb
    begin
        case (i_op)
            ALU_ADD:    o_result = sum[31:0];
            ALU_SUB:    o_result = sum[31:0];
            ALU_SLT:    o_result = {31'b0, lt_s};
            ALU_SLTU:   o_result = {31'b0, lt_u};
            ALU_XOR:    o_result = i_op_a ^ i_op_b;
            ALU_OR:     o_result = i_op_a | i_op_b;
            ALU_AND:    o_result = i_op_a & i_op_b;
            ALU_PASS_B: o_result = i_op_b;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_shifter.sv
`default_nettype none

module rv_shifter
    import rv_pipe_pkg::*;
(
    input  wire word_t     i_op_a,
    input  wire shamt_t    i_shamt,
    input  wire shift_op_t i_op,
    output word_t          o_result
);

    function automatic word_t bit_rev(input word_t x);
        word_t r;
        for (int i = 0; i < 32; i++)
            r[i] = x[31-i];
        return r;
    endfunction

    word_t stage [0:5];
    logic  fill;

    // left shifts run through the right shifter mirrored
    assign fill     = (i_op == SH_SRA) && i_op_a[31];
    assign stage[0] = (i_op == SH_SLL) ? bit_rev(i_op_a) : i_op_a;

    for (genvar k = 0; k < 5; k++)
    begin : g_level
        assign stage[k+1] = i_shamt[k] ? {{(2**k){fill}}, stage[k][31:2**k]} : stage[k];
    end

    assign o_result = (i_op == SH_SLL) ? bit_rev(stage[5]) : stage[5];

endmodule

`default_nettype wire

// File: source/rv_writeback.sv
`default_nettype none

module rv_writeback
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_arst_n,
    input  wire           i_valid,
    input  wire           i_illegal,
    input  wire reg_idx_t i_rd,
    input  wire res_sel_t i_res_sel,
    input  wire word_t    i_alu_result,
    input  wire word_t    i_shift_result,
    output logic          o_ex_valid,
    output reg_idx_t      o_ex_rd,
    output word_t         o_ex_data,
    output logic          o_wb_valid,
    output reg_idx_t      o_wb_rd,
    output word_t         o_wb_data,
    output logic          o_illegal
);

    // execute-stage result, also the first forward path
    assign o_ex_valid = i_valid;
    assign o_ex_rd    = i_rd;
    assign o_ex_data  = (i_res_sel == RES_SHIFT) ? i_shift_result : i_alu_result;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
        end
        else
        begin
            o_wb_valid <= o_ex_valid;
            o_illegal  <= i_illegal;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_ex_valid)
        begin
            o_wb_rd   <= o_ex_rd;
            o_wb_data <= o_ex_data;   // also feeds the second forward path.
        end
    end

endmodule

`default_nettype wire

// File: source/rv_core_top.sv
`default_nettype none

module rv_core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  wire           i_clk,
    input  wire           i_arst_n,
    input  wire           i_instr_valid,
    input  wire instr_t   i_instr,
    output wire           o_credit,
    output wire           o_wb_valid,
    output wire reg_idx_t o_wb_rd,
    output wire word_t    o_wb_data,
    output wire           o_illegal
);

    logic      q_valid;
    instr_t    q_instr;
    reg_idx_t  rf_rs1;
    reg_idx_t  rf_rs2;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;
    logic      d_valid;
    logic      d_illegal;
    word_t     d_op_a;
    word_t     d_op_b;
    alu_op_t   d_alu_op;
    shift_op_t d_shift_op;
    res_sel_t  d_res_sel;
    reg_idx_t  d_rd;
    word_t     alu_result;
    word_t     shift_result;
    logic      ex_valid;
    reg_idx_t  ex_rd;
    word_t     ex_data;

    rv_instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_instr_valid),
        .i_instr  (i_instr),
        .o_valid  (q_valid),
        .o_instr  (q_instr),
        .o_credit (o_credit)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1      (rf_rs1),
        .i_rs2      (rf_rs2),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data),
        .i_we       (o_wb_valid),
        .i_rd       (o_wb_rd),
        .i_wdata    (o_wb_data)
    );

    // ****************************************
    // decode and execute stages
    // ****************************************
    rv_decode u_decode (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (q_valid),
        .i_instr    (q_instr),
        .o_rs1      (rf_rs1),
        .o_rs2      (rf_rs2),
        .i_rs1_data (rf_rs1_data),
        .i_rs2_data (rf_rs2_data),
        .i_ex_valid (ex_valid),
        .i_ex_rd    (ex_rd),
        .i_ex_data  (ex_data),
        .i_wb_valid (o_wb_valid),
        .i_wb_rd    (o_wb_rd),
        .i_wb_data  (o_wb_data),
        .o_valid    (d_valid),
        .o_illegal  (d_illegal),
        .o_op_a     (d_op_a),
        .o_op_b     (d_op_b),
        .o_alu_op   (d_alu_op),
        .o_shift_op (d_shift_op),
        .o_res_sel  (d_res_sel),
        .o_rd       (d_rd)
    );

    rv_alu u_alu (
        .i_op_a   (d_op_a),
        .i_op_b   (d_op_b),
        .i_op     (d_alu_op),
        .o_result (alu_result)
    );

    rv_shifter u_shifter (
        .i_op_a   (d_op_a),
        .i_shamt  (d_op_b[4:0]),        // rs2 or immediate shamt.
        .i_op     (d_shift_op),
        .o_result (shift_result)
    );

    rv_writeback u_writeback (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_valid        (d_valid),
        .i_illegal      (d_illegal),
        .i_rd           (d_rd),
        .i_res_sel      (d_res_sel),
        .i_alu_result   (alu_result),
        .i_shift_result (shift_result),
        .o_ex_valid     (ex_valid),
        .o_ex_rd        (ex_rd),
        .o_ex_data      (ex_data),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data),
        .o_illegal      (o_illegal)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
)
(
    output logic o_clk,
    output logic o_arst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever
            #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge o_clk);
        o_arst_n <= 1'b1;       // released on a rising edge.
    end

endmodule

`default_nettype wire

// File: tests/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    localparam int QUEUE_DEPTH = 4;
    localparam int N_ALU       = 80;
    localparam int N_SHIFT     = 60;
    localparam int N_CHAIN     = 40;
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        credit;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] model_regs [32];
    logic [37:0] exp_q [$];         // {legal, rd, data}.
    int          n_sent;
    int          n_credit_pulses;
    int          n_outputs_expected;
    int          n_outputs_seen;
    int          n_checks;
    int          n_errors;
    int          n_cycles;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (4)
    ) clock_gen_i (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    rv_core_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) rv_core_top_i (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_credit      (credit),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data),
        .o_illegal     (illegal)
    );

    // ****************************************
    // encoders and reference model
    // ****************************************
    function automatic logic [31:0] encode_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] encode_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom);
    endfunction

    // rv32i semantics on the model registers in program order
    function automatic void reference_result(input logic [31:0] word, output logic legal,
                                             output logic [4:0] rd, output logic [31:0] data);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               reg_form;
        logic               alt;
        opc      = word[6:0];
        f3       = word[14:12];
        f7       = word[31:25];
        rd       = word[11:7];
        reg_form = (opc == OP_REG);
        alt      = (f7 == 7'h20);
        a        = model_regs[word[19:15]];
        b        = reg_form ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sa       = a;
        sb       = b;
        legal    = 1'b1;
        data     = '0;
        if (opc == OP_LUI)
            data = {word[31:12], 12'h000};
        else if (opc == OP_REG || opc == OP_IMM)
        begin
            case (f3)
                3'd0: data = (reg_form && alt) ? a - b : a + b;
                3'd1: data = a << b[4:0];
                3'd2: data = {31'b0, sa < sb};
                3'd3: data = {31'b0, a < b};
                3'd4: data = a ^ b;
                3'd5:
                begin
                    if (alt)
                        data = sa >>> b[4:0];
                    else
                        data = a >> b[4:0];
                end
                3'd6: data = a | b;
                3'd7: data = a & b;
            endcase
            if (reg_form)
                legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            else if (f3 == 3'd1)
                legal = (f7 == 7'h00);
            else if (f3 == 3'd5)
                legal = (f7 == 7'h00) || alt;
        end
        else
            legal = 1'b0;
        if (legal && rd != 5'd0)
            model_regs[rd] = data;
    endfunction

    function automatic logic [31:0] random_alu_word();
        logic [2:0] f3;
        logic [6:0] f7;
        do
            f3 = 3'($urandom);
        while (f3 == 3'd1 || f3 == 3'd5);
        f7 = (f3 == 3'd0 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
        case ($urandom % 3)
            0:       return encode_reg(f7, rand_reg(), rand_reg(), f3, rand_reg());
            1:       return encode_imm(12'($urandom), rand_reg(), f3, rand_reg());
            default: return encode_lui(20'($urandom), rand_reg());
        endcase
    endfunction

    function automatic logic [31:0] random_shift_word();
        logic [2:0] f3;
        logic       alt;
        f3  = ($urandom % 2 == 1) ? 3'd5 : 3'd1;
        alt = (f3 == 3'd5) && ($urandom % 2 == 1);
        if ($urandom % 2 == 1)
            return encode_reg({1'b0, alt, 5'b0}, rand_reg(), rand_reg(), f3, rand_reg());
        else
            return encode_imm({1'b0, alt, 5'b0, 5'($urandom)}, rand_reg(), f3, rand_reg());
    endfunction

    // legal writes to x0 leave no trace at the outputs
    function automatic void skip_silent();
        while (exp_q.size() != 0 && exp_q[0][37] && exp_q[0][36:32] == 5'd0)
            void'(exp_q.pop_front());
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        n_errors++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
    endtask

    // ****************************************
    // stimulus
    // ****************************************
    task automatic send_instr(input logic [31:0] word);
        logic        legal;
        logic [4:0]  rd;
        logic [31:0] data;
        @(posedge clk);
        while (n_sent - n_credit_pulses >= QUEUE_DEPTH)     // out of credits.
        begin
            instr_valid <= 1'b0;
            @(posedge clk);
        end
        instr_valid <= 1'b1;
        instr       <= word;
        n_sent++;
        reference_result(word, legal, rd, data);
        exp_q.push_back({legal, rd, data});
        if (!legal || rd != 5'd0)
            n_outputs_expected++;
    endtask

    task automatic pause(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        @(posedge clk);
        instr_valid <= 1'b0;
        while (n_outputs_seen < n_outputs_expected || n_credit_pulses < n_sent)
            @(posedge clk);
        repeat (5)
            @(posedge clk);
    endtask

    task automatic dependent_chain(input int count);
        logic [4:0] prev;
        logic [4:0] prev2;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [6:0] f7;
        prev  = 5'd1;
        prev2 = 5'd2;
        for (int n = 0; n < count; n++)
        begin
            rd = 5'(1 + $urandom % 7);
            f3 = 3'($urandom);
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
            if (n % 3 == 2)
                send_instr(encode_imm(12'($urandom), prev2, 3'd0, rd));
            else if (n % 3 == 1)
                send_instr(encode_reg(f7, prev, prev2, f3, rd));    // newest result on rs2.
            else
                send_instr(encode_reg(f7, prev2, prev, f3, rd));
            prev2 = prev;
            prev  = rd;
        end
    endtask

    always @(posedge clk)
    begin
        if (credit)
            n_credit_pulses <= n_credit_pulses + 1;
    end

    // ****************************************
    // compare
    // ****************************************
    always @(posedge clk)
    begin : compare
        logic [37:0] e;
        if (wb_valid || illegal)
        begin
            skip_silent();
            if (exp_q.size() == 0)
            begin
                n_errors++;
                $display("output at %0t with no instruction outstanding", $time);
            end
            else
            begin
                e = exp_q.pop_front();
                n_outputs_seen++;
                n_checks++;
                if (!e[37])
                begin
                    if (illegal !== 1'b1)
                        report_mismatch("o_illegal", 32'(illegal), 32'd1);
                    if (wb_valid !== 1'b0)
                        report_mismatch("o_wb_valid", 32'(wb_valid), 32'd0);
                end
                else
                begin
                    if (wb_valid !== 1'b1)
                        report_mismatch("o_wb_valid", 32'(wb_valid), 32'd1);
                    if (illegal !== 1'b0)
                        report_mismatch("o_illegal", 32'(illegal), 32'd0);
                    if (wb_rd !== e[36:32])
                        report_mismatch("o_wb_rd", 32'(wb_rd), 32'(e[36:32]));
                    if (wb_data !== e[31:0])
                        report_mismatch("o_wb_data", wb_data, e[31:0]);
                end
            end
        end
    end

    initial
    begin
        n_cycles = 0;
        while (n_cycles <= 20 * n_sent + 100)
        begin
            @(posedge clk);
            n_cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d results seen",
                 n_cycles, n_outputs_seen, n_outputs_expected);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h81bc0da1));
        instr_valid        = 1'b0;
        instr              = '0;
        n_sent             = 0;
        n_credit_pulses    = 0;
        n_outputs_expected = 0;
        n_outputs_seen     = 0;
        n_checks           = 0;
        n_errors           = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        wait (arst_n === 1'b1);
        repeat (3)
        begin
            @(posedge clk);
            if (credit !== 1'b0 || wb_valid !== 1'b0 || illegal !== 1'b0)
            begin
                n_errors++;
                $display("outputs active at %0t before any instruction was sent", $time);
            end
        end
        send_instr(encode_imm(12'h5a5, 5'd0, 3'd0, 5'd1));     // addi x1, x0.
        pause(2);
        for (int n = 0; n < N_ALU; n++)
        begin
            send_instr(random_alu_word());
            pause($urandom % 3);
        end
        for (int n = 0; n < N_SHIFT; n++)
        begin
            if (n % 4 == 0)
                send_instr(encode_lui({1'b1, 19'($urandom)}, rand_reg()));
            send_instr(random_shift_word());
            pause($urandom % 3);
        end
        dependent_chain(N_CHAIN);
        drain();
        for (int n = 0; n < QUEUE_DEPTH; n++)
            send_instr(random_alu_word());
        drain();
        send_instr(32'h0000_2083);                              // lw is unsupported.
        send_instr(encode_reg(7'h01, 5'd2, 5'd1, 3'd0, 5'd4));  // mul.
        send_instr(encode_imm(12'h405, 5'd3, 3'd1, 5'd5));      // slli with bad funct7.
        send_instr(32'h0000_006f);                              // jal x0.
        send_instr(encode_reg(7'h00, 5'd0, 5'd4, 3'd0, 5'd8));
        send_instr(encode_imm(12'h123, 5'd1, 3'd0, 5'd0));
        send_instr(encode_lui(20'hfffff, 5'd0));
        send_instr(encode_reg(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
        send_instr(encode_reg(7'h00, 5'd0, 5'd1, 3'd6, 5'd7));
        drain();
        skip_silent();
        if (exp_q.size() != 0)
        begin
            n_errors++;
            $display("%0d instructions never completed", exp_q.size());
        end
        if (n_credit_pulses != n_sent)
        begin
            n_errors++;
            $display("%0d credit pulses for %0d instructions sent", n_credit_pulses, n_sent);
        end
        $display("sent %0d, checks %0d, errors %0d", n_sent, n_checks, n_errors);
        if (n_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/rv_instr_queue.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_shifter.sv
source/rv_writeback.sv
source/rv_core_top.sv
tests/tb_clock_gen.sv
tests/tb_rv_core.sv

// File: Makefile
# Verilator build and run of the core testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
